//--- bench/tb_tx_core.sv
`timescale 1ns/10ps

module tb_tx_core;

   logic                      clk;
   logic                      rst_n;
   logic                      clear;
   logic                      set_stb;
   logic [tx_pkg::ADDR_W-1:0] set_addr;
   logic [tx_pkg::SET_W-1:0]  set_data;
   tx_pkg::vtime_t            vita_time;
   tx_pkg::beat_t             in_data;
   logic                      in_valid;
   logic                      in_ready;
   logic                      strobe;
   tx_pkg::sample_t           sample;
   logic                      run;
   logic                      ack_or_error;
   tx_pkg::err_code_t         error_code;
   tx_pkg::seqnum_t           seqnum;
   tx_pkg::sid_t              sid;
   logic                      packet_consumed;

   integer         fd;
   integer         rc;
   integer         lines = 0;
   integer         cycle_count = 0;
   integer         cycle_limit = 1000;
   logic           event_armed;   // an ack is allowed only while armed
   logic [31:0]    cmd;
   logic [8*128-1:0] line_buf;
   logic [63:0]    f0, f1, f2, f3, f4, f5, f6, f7;

   // beats handed to the DUT and not yet consumed, oldest first
   logic [11:0]    pushed_seq [$];
   logic [31:0]    pushed_sid [$];
   logic           pushed_eop [$];

   tx_core DUT (.*);

   always #4 clk = !clk;

   task automatic report_failure(input string what);
      $display("error at %0t: %s", $time, what);
      $display("Simulation FAILED");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
         $display("Simulation FAILED");
         $fatal(1, "stopping on first error");
      end
   endtask

   // the consumed packet is the oldest pushed end-of-packet beat
   task automatic check_packet_consumed();
      int idx;
      idx = -1;
      for (int i = 0; i < pushed_eop.size(); i++)
         if (idx < 0 && pushed_eop[i])
            idx = i;
      if (idx < 0)
         report_failure("a packet was consumed that was never pushed");
      else
      begin
         check_value("seqnum", seqnum, pushed_seq[idx]);
         check_value("sid", sid, pushed_sid[idx]);
         repeat (idx + 1)
         begin
            pushed_seq.delete(0);
            pushed_sid.delete(0);
            pushed_eop.delete(0);
         end
      end
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
         report_failure("timeout, the DUT stopped responding");
   end

   always @(negedge clk)   // no ack outside an expected event
      if (rst_n && !event_armed)
         check_value("ack_or_error", ack_or_error, 0);

   always @(negedge clk)
      if (rst_n && packet_consumed)
         check_packet_consumed();

   ////////////////////////////////////////////////////////////////////////////
   // commands

   task automatic write_policy(input logic [31:0] word);
      @(posedge clk);
      set_stb  <= 1'b1;
      set_addr <= tx_pkg::POLICY_ADDR;
      set_data <= word;
      @(posedge clk);
      set_stb  <= 1'b0;
   endtask

   task automatic push_beat();
      logic [31:0] beat_sid;
      beat_sid = {20'h51d00, f0[11:0]};   // distinct per packet
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= {f4[0], f3[0], f2[0], f1[0], f0[11:0], beat_sid,
                   f5, f6[31:0], f7[31:0]};
      do
         @(negedge clk);
      while (!in_ready);   // hold the word while full
      pushed_seq.push_back(f0[11:0]);
      pushed_sid.push_back(beat_sid);
      pushed_eop.push_back(f1[0]);
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic expect_sample(input logic chk, input logic [31:0] value);
      do
         @(negedge clk);
      while (!run);
      repeat ($urandom % 3) @(negedge clk);
      @(posedge clk);
      strobe <= 1'b1;
      @(negedge clk);
      if (chk)
         check_value("sample", sample, value);
      @(posedge clk);
      strobe <= 1'b0;
   endtask

   task automatic expect_event(input logic [31:0] flag, input logic [11:0] exp_seq,
                               input logic [11:0] got_seq, input logic chk_low);
      logic [63:0] code;
      code = {flag, 4'h0, exp_seq, 4'h0, got_seq};
      event_armed = 1'b1;
      do
         @(negedge clk);
      while (!ack_or_error);
      if (chk_low)
         check_value("error_code", error_code, code);
      else
         check_value("error_code flag", error_code[63:32], code[63:32]);
      check_value("run", run, 0);   // no sample state after an event
      @(posedge clk);
      event_armed = 1'b0;
   endtask

   task automatic hold_check(input integer cycles, input logic exp_run);
      repeat (cycles)
      begin
         @(negedge clk);
         check_value("run", run, exp_run);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main

   initial
   begin
      clk = 0;
      rst_n = 0;
      clear = 0;
      set_stb = 0;
      set_addr = 0;
      set_data = 0;
      vita_time = 0;
      in_data = 0;
      in_valid = 0;
      strobe = 0;
      event_armed = 0;
      void'($urandom(92716));
      fd = $fopen("bench/tx_testdata.txt", "r");
      if (fd == 0)
         report_failure("cannot open the test data file");
      while (!$feof(fd))
      begin
         rc = $fgets(line_buf, fd);
         if (rc > 0)
            lines = lines + 1;
      end
      $fclose(fd);
      cycle_limit = 40 * lines;
      fd = $fopen("bench/tx_testdata.txt", "r");
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      rc = $fscanf(fd, "%s", cmd);
      while (rc == 1)
      begin
         if (cmd == "#")
            rc = $fgets(line_buf, fd);   // comment line
         else if (cmd == "P")
         begin
            rc = $fscanf(fd, "%h", f0);
            write_policy(f0[31:0]);
         end
         else if (cmd == "T")
         begin
            rc = $fscanf(fd, "%h", f0);
            @(posedge clk);
            vita_time <= f0;
         end
         else if (cmd == "B")
         begin
            rc = $fscanf(fd, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
            push_beat();
         end
         else if (cmd == "S")
         begin
            rc = $fscanf(fd, "%h %h", f0, f1);
            expect_sample(f0[0], f1[31:0]);
         end
         else if (cmd == "E")
         begin
            rc = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
            expect_event(f0[31:0], f1[11:0], f2[11:0], f3[0]);
         end
         else if (cmd == "R")
         begin
            rc = $fscanf(fd, "%h %h", f0, f1);
            hold_check(f0[31:0], f1[0]);
         end
         else
            report_failure("unknown command in the test data file");
         rc = $fscanf(fd, "%s", cmd);
      end
      $fclose(fd);
      if (pushed_seq.size() != 0)
         report_failure("pushed beats were never consumed by the DUT");
      else
      begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

//--- bench/tx_testdata.txt
# fields in hex. P policy | T vita_time | B seq eop eob send_at odd time s0 s1
# S check sample | E flag expected_seq seq check_low | R cycles run
P 2
B 0 0 0 0 0 ffffffffffffffff 00010001 00010002
B 0 1 1 0 0 ffffffffffffffff 00010003 00010004
S 1 00010001
S 1 00010002
S 1 00010003
S 1 00010004
E 1 0 0 1
B 1 1 1 0 1 ffffffffffffffff 00020001 0002dead
S 1 00020001
E 1 0 1 1
B 5 1 1 0 0 ffffffffffffffff 00030001 00030002
E 4 2 5 1
B 6 1 0 0 0 ffffffffffffffff 00040001 00040002
B 8 1 1 0 0 ffffffffffffffff 00050001 00050002
S 1 00040001
S 1 00040002
S 1 00050001
E 20 7 8 1
B 9 1 0 0 0 ffffffffffffffff 00060001 00060002
S 1 00060001
S 1 00060002
S 0 0
E 2 0 0 0
B a 1 1 0 0 ffffffffffffffff 00070001 00070002
P 4
B 3 1 0 0 0 ffffffffffffffff 000a0001 000a0002
E 4 0 3 1
B 4 1 1 0 0 ffffffffffffffff 000b0001 000b0002
R 4 0
P 4
B 0 1 1 0 1 ffffffffffffffff 00080001 00000000
S 1 00080001
E 1 0 0 1
P 2
T 800
B 0 1 1 1 0 1000 00090001 00090002
R 6 0
T 1000
S 1 00090001
S 1 00090002
E 1 0 0 1
B 1 1 1 1 0 10 000c0001 000c0002
E 8 0 1 1

//--- files.f
source/tx_pkg.sv
source/tx_beat_if.sv
source/tx_beat_fifo.sv
source/tx_policy_regs.sv
source/time_compare.sv
source/tx_control.sv
source/tx_core.sv
bench/tb_tx_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tx_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_tx_core -f files.f -o sim_tx_core \
   && ./obj_dir/sim_tx_core | grep -q "Simulation PASSED" \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }

//--- source/time_compare.sv
`timescale 1ns/10ps

module time_compare
(
   input  logic           clk,
   input  logic           rst_n,
   input  tx_pkg::vtime_t time_now,
   input  tx_pkg::vtime_t trigger_time,
   output logic           now,
   output logic           early,
   output logic           late,
   output logic           too_early
);

   tx_pkg::vtime_t lead;   // ticks until trigger

   assign lead = trigger_time - time_now;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         now       <= 1'b0;
         early     <= 1'b0;
         late      <= 1'b0;
         too_early <= 1'b0;
      end
      else
      begin
         now       <= (time_now == trigger_time);
         early     <= (time_now < trigger_time);
         late      <= (time_now > trigger_time);
         too_early <= (time_now < trigger_time) && (lead > tx_pkg::TOO_EARLY_TICKS);
      end
   end

endmodule

//--- source/tx_beat_fifo.sv
`timescale 1ns/10ps

module tx_beat_fifo
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          clear,
   input  tx_pkg::beat_t in_data,
   input  logic          in_valid,
   output logic          in_ready,
   tx_beat_if.fifo       beat
);

   tx_pkg::beat_t              mem [tx_pkg::FIFO_DEPTH];
   tx_pkg::beat_t              head;
   logic [tx_pkg::PTR_W-1:0]   wr_ptr;
   logic [tx_pkg::PTR_W-1:0]   rd_ptr;
   logic [tx_pkg::PTR_W:0]     count;
   logic                       full;
   logic                       push;
   logic                       pop;

   assign full     = (count == tx_pkg::FIFO_COUNT_FULL);
   assign in_ready = !full;
   assign push     = in_valid && in_ready;
   assign pop      = beat.valid && beat.ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n || clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // head entry unpacked
   assign head           = mem[rd_ptr];
   assign beat.valid     = (count != '0);
   assign beat.sample1   = head[tx_pkg::SAMPLE1_LSB +: tx_pkg::SAMPLE_W];
   assign beat.sample0   = head[tx_pkg::SAMPLE0_LSB +: tx_pkg::SAMPLE_W];
   assign beat.send_time = head[tx_pkg::TIME_LSB +: tx_pkg::TIME_W];
   assign beat.sid       = head[tx_pkg::SID_LSB +: tx_pkg::SID_W];
   assign beat.seqnum    = head[tx_pkg::SEQ_LSB +: tx_pkg::SEQ_W];
   assign beat.eop       = head[tx_pkg::EOP_BIT];
   assign beat.eob       = head[tx_pkg::EOB_BIT];
   assign beat.send_at   = head[tx_pkg::SEND_AT_BIT];
   assign beat.odd       = head[tx_pkg::ODD_BIT];

   // a full buffer takes no write, so the write side cannot move
   no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n || clear)
      full |=> $stable(wr_ptr));

endmodule

//--- source/tx_beat_if.sv
`timescale 1ns/10ps

interface tx_beat_if;

   tx_pkg::sample_t sample0;
   tx_pkg::sample_t sample1;
   tx_pkg::vtime_t  send_time;
   tx_pkg::sid_t    sid;
   tx_pkg::seqnum_t seqnum;
   logic            eop;
   logic            eob;
   logic            send_at;
   logic            odd;
   logic            valid;
   logic            ready;   // pop on valid & ready

   modport fifo
   (
      output sample0, sample1, send_time, sid, seqnum,
      output eop, eob, send_at, odd, valid,
      input  ready
   );

   modport ctrl
   (
      input  sample0, sample1, send_time, sid, seqnum,
      input  eop, eob, send_at, odd, valid,
      output ready
   );

endinterface

//--- source/tx_control.sv
`timescale 1ns/10ps

module tx_control
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               clear,
   tx_beat_if.ctrl            beat,
   input  logic               now,
   input  logic               late,
   input  logic               policy_wait,
   input  logic               policy_next_packet,
   input  logic               policy_next_burst,
   input  logic               clear_seqnum,
   input  logic               strobe,
   output tx_pkg::sample_t    sample,
   output logic               run,
   output logic               ack_or_error,
   output tx_pkg::err_code_t  error_code,
   output logic               packet_consumed
);

   tx_pkg::tx_state_e state;
   tx_pkg::seqnum_t   expected_seqnum;
   logic              seq_bad;
   logic              odd_last;

   function automatic tx_pkg::err_code_t make_code
   (
      input logic [tx_pkg::FLAG_W-1:0] flag,
      input tx_pkg::seqnum_t           expected,
      input tx_pkg::seqnum_t           got
   );
      tx_pkg::err_code_t code;
      code = '0;
      code[tx_pkg::CODE_FLAG_LSB +: tx_pkg::FLAG_W] = flag;
      code[tx_pkg::CODE_EXP_LSB +: tx_pkg::SEQ_W]   = expected;
      code[tx_pkg::SEQ_W-1:0]                       = got;
      return code;
   endfunction

   assign seq_bad  = (expected_seqnum != beat.seqnum);
   assign odd_last = beat.eop && beat.odd;

   ////////////////////////////////////////////////////////////////////////////
   // dsp side
   assign run    = (state == tx_pkg::ST_SAMP0) || (state == tx_pkg::ST_SAMP1);
   assign sample = (state == tx_pkg::ST_SAMP0) ? beat.sample0 : beat.sample1;

   assign beat.ready = (state == tx_pkg::ST_ERROR)
                     || (strobe && ((state == tx_pkg::ST_SAMP1)
                     || ((state == tx_pkg::ST_SAMP0) && odd_last)));

   assign packet_consumed = beat.eop && beat.valid && beat.ready;

   // last consumed packet plus one
   always_ff @(posedge clk)
   begin
      if (!rst_n || clear || clear_seqnum)
         expected_seqnum <= '0;
      else if (packet_consumed)
         expected_seqnum <= beat.seqnum + 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // release fsm
   always_ff @(posedge clk)
   begin
      if (!rst_n || clear)
      begin
         state        <= tx_pkg::ST_IDLE;
         ack_or_error <= 1'b0;
         error_code   <= '0;
      end
      else
      begin
         ack_or_error <= 1'b0;
         case (state)
            tx_pkg::ST_IDLE:
            begin
               if (beat.valid)
               begin
                  if (!beat.send_at || now)
                  begin
                     if (seq_bad)
                     begin
                        state        <= tx_pkg::ST_ERROR;
                        ack_or_error <= 1'b1;
                        error_code   <= make_code(tx_pkg::FLAG_SEQ_ERROR,
                                                  expected_seqnum, beat.seqnum);
                     end
                     else
                        state <= tx_pkg::ST_SAMP0;
                  end
                  else if (late)   // missed its slot
                  begin
                     state        <= tx_pkg::ST_ERROR;
                     ack_or_error <= 1'b1;
                     error_code   <= make_code(tx_pkg::FLAG_TIME_ERROR, '0, beat.seqnum);
                  end
               end
            end
            tx_pkg::ST_SAMP0:
            begin
               if (strobe)
               begin
                  if (!beat.valid)
                  begin
                     state        <= tx_pkg::ST_ERROR;
                     ack_or_error <= 1'b1;
                     error_code   <= make_code(tx_pkg::FLAG_UNDERRUN, '0, beat.seqnum);
                  end
                  else if (odd_last && beat.eob)
                  begin
                     state        <= tx_pkg::ST_IDLE;
                     ack_or_error <= 1'b1;
                     error_code   <= make_code(tx_pkg::FLAG_EOB_ACK, '0, beat.seqnum);
                  end
                  else if (odd_last)
                     state <= tx_pkg::ST_SAMP0;   // burst goes on
                  else if (seq_bad)
                  begin
                     state        <= tx_pkg::ST_ERROR;
                     ack_or_error <= 1'b1;
                     error_code   <= make_code(tx_pkg::FLAG_SEQ_ERROR_MIDBURST,
                                               expected_seqnum, beat.seqnum);
                  end
                  else
                     state <= tx_pkg::ST_SAMP1;
               end
            end
            tx_pkg::ST_SAMP1:
            begin
               if (strobe)
               begin
                  if (beat.eop && beat.eob)
                  begin
                     state        <= tx_pkg::ST_IDLE;
                     ack_or_error <= 1'b1;
                     error_code   <= make_code(tx_pkg::FLAG_EOB_ACK, '0, beat.seqnum);
                  end
                  else
                     state <= tx_pkg::ST_SAMP0;
               end
            end
            tx_pkg::ST_ERROR:
            begin
               // drain to end of packet
               if (beat.valid && beat.eop)
               begin
                  if (policy_next_packet || (policy_next_burst && beat.eob))
                     state <= tx_pkg::ST_IDLE;
                  else if (policy_wait)
                     state <= tx_pkg::ST_WAIT;
               end
            end
            tx_pkg::ST_WAIT:
               state <= tx_pkg::ST_WAIT;   // only clear leaves
            default:
               state <= tx_pkg::ST_IDLE;
         endcase
      end
   end

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack_or_error |=> !ack_or_error);

   // samples start only from idle
   run_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(run) |-> $past(state == tx_pkg::ST_IDLE));

   no_pop_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (state == tx_pkg::ST_IDLE) |-> !beat.ready);

endmodule

//--- source/tx_core.sv
`timescale 1ns/10ps

module tx_core
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      clear,
   input  logic                      set_stb,
   input  logic [tx_pkg::ADDR_W-1:0] set_addr,
   input  logic [tx_pkg::SET_W-1:0]  set_data,
   input  tx_pkg::vtime_t            vita_time,
   input  tx_pkg::beat_t             in_data,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  logic                      strobe,
   output tx_pkg::sample_t           sample,
   output logic                      run,
   output logic                      ack_or_error,
   output tx_pkg::err_code_t         error_code,
   output tx_pkg::seqnum_t           seqnum,
   output tx_pkg::sid_t              sid,
   output logic                      packet_consumed
);

   logic now;
   logic late;
   logic policy_wait;
   logic policy_next_packet;
   logic policy_next_burst;
   logic clear_seqnum;

   tx_beat_if beat ();

   assign seqnum = beat.seqnum;
   assign sid    = beat.sid;

   tx_beat_fifo u_fifo
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (clear),
      .in_data  (in_data),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .beat     (beat.fifo)
   );

   tx_policy_regs u_policy
   (
      .clk                (clk),
      .rst_n              (rst_n),
      .set_stb            (set_stb),
      .set_addr           (set_addr),
      .set_data           (set_data),
      .policy_wait        (policy_wait),
      .policy_next_packet (policy_next_packet),
      .policy_next_burst  (policy_next_burst),
      .clear_seqnum       (clear_seqnum)
   );

   // head beat's send time against radio time
   time_compare u_time
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .time_now     (vita_time),
      .trigger_time (beat.send_time),
      .now          (now),
      .early        (),
      .late         (late),
      .too_early    ()
   );

   tx_control u_ctrl
   (
      .clk                (clk),
      .rst_n              (rst_n),
      .clear              (clear),
      .beat               (beat.ctrl),
      .now                (now),
      .late               (late),
      .policy_wait        (policy_wait),
      .policy_next_packet (policy_next_packet),
      .policy_next_burst  (policy_next_burst),
      .clear_seqnum       (clear_seqnum),
      .strobe             (strobe),
      .sample             (sample),
      .run                (run),
      .ack_or_error       (ack_or_error),
      .error_code         (error_code),
      .packet_consumed    (packet_consumed)
   );

endmodule

//--- source/tx_pkg.sv
package tx_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   localparam int SAMPLE_W = 32;
   localparam int TIME_W   = 64;
   localparam int SEQ_W    = 12;
   localparam int SID_W    = 32;
   localparam int CODE_W   = 64;
   localparam int FLAG_W   = 32;
   localparam int BEAT_W   = 176;
   localparam int ADDR_W   = 8;
   localparam int SET_W    = 32;

   typedef logic [SAMPLE_W-1:0] sample_t;   // two 16-bit halves
   typedef logic [TIME_W-1:0]   vtime_t;
   typedef logic [SEQ_W-1:0]    seqnum_t;
   typedef logic [SID_W-1:0]    sid_t;
   typedef logic [CODE_W-1:0]   err_code_t;
   typedef logic [BEAT_W-1:0]   beat_t;

   ////////////////////////////////////////////////////////////////////////////
   // beat layout, low bits first
   localparam int SAMPLE1_LSB = 0;
   localparam int SAMPLE0_LSB = 32;
   localparam int TIME_LSB    = 64;
   localparam int SID_LSB     = 128;
   localparam int SEQ_LSB     = 160;
   localparam int EOP_BIT     = 172;
   localparam int EOB_BIT     = 173;
   localparam int SEND_AT_BIT = 174;
   localparam int ODD_BIT     = 175;

   // beat buffer
   localparam int FIFO_DEPTH = 4;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam logic [PTR_W:0] FIFO_COUNT_FULL = (PTR_W + 1)'(FIFO_DEPTH);

   // error policy register
   localparam logic [ADDR_W-1:0] POLICY_ADDR = 8'h20;
   localparam int POL_WAIT_BIT        = 0;
   localparam int POL_NEXT_PACKET_BIT = 1;
   localparam int POL_NEXT_BURST_BIT  = 2;

   localparam vtime_t TOO_EARLY_TICKS = 64'd1 << 28;

   ////////////////////////////////////////////////////////////////////////////
   // status code, flag in the upper half
   localparam int CODE_EXP_LSB  = 16;
   localparam int CODE_FLAG_LSB = 32;
   localparam logic [FLAG_W-1:0] FLAG_EOB_ACK            = 32'd1;
   localparam logic [FLAG_W-1:0] FLAG_UNDERRUN           = 32'd2;
   localparam logic [FLAG_W-1:0] FLAG_SEQ_ERROR          = 32'd4;
   localparam logic [FLAG_W-1:0] FLAG_TIME_ERROR         = 32'd8;
   localparam logic [FLAG_W-1:0] FLAG_UNDERRUN_MIDPKT    = 32'd16;
   localparam logic [FLAG_W-1:0] FLAG_SEQ_ERROR_MIDBURST = 32'd32;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SAMP0,
      ST_SAMP1,
      ST_ERROR,
      ST_WAIT
   } tx_state_e;

endpackage

//--- source/tx_policy_regs.sv
`timescale 1ns/10ps

module tx_policy_regs
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      set_stb,
   input  logic [tx_pkg::ADDR_W-1:0] set_addr,
   input  logic [tx_pkg::SET_W-1:0]  set_data,
   output logic                      policy_wait,
   output logic                      policy_next_packet,
   output logic                      policy_next_burst,
   output logic                      clear_seqnum
);

   logic hit;

   assign hit = set_stb && (set_addr == tx_pkg::POLICY_ADDR);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         policy_wait        <= 1'b0;
         policy_next_packet <= 1'b0;
         policy_next_burst  <= 1'b0;
         clear_seqnum       <= 1'b0;
      end
      else
      begin
         clear_seqnum <= hit;   // one cycle per write
         if (hit)
         begin
            policy_wait        <= set_data[tx_pkg::POL_WAIT_BIT];
            policy_next_packet <= set_data[tx_pkg::POL_NEXT_PACKET_BIT];
            policy_next_burst  <= set_data[tx_pkg::POL_NEXT_BURST_BIT];
         end
      end
   end

endmodule
